/* Makefile */
TOP := rv_exec_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f rv_exec.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null

clean:
	rm -rf obj_dir

/* rv_alu.sv */
`default_nettype none

`include "rv_exec_consts.svh"

module rv_alu import rv_exec_pkg::*; (
  input  wire logic [`RV_XLEN-1:0] a_i,
  input  wire logic [`RV_XLEN-1:0] b_i,
  input  wire alu_op_e             op_i,
  output logic      [`RV_XLEN-1:0] y_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  y_o = a_i + b_i;
      ALU_SUB:  y_o = a_i - b_i;
      ALU_XOR:  y_o = a_i ^ b_i;
      ALU_OR:   y_o = a_i | b_i;
      ALU_AND:  y_o = a_i & b_i;
      ALU_SLL:  y_o = a_i << shamt;
      ALU_SRL:  y_o = a_i >> shamt;
      ALU_SRA:  y_o = $signed(a_i) >>> shamt;
      ALU_SLT:  y_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: y_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
      ALU_SGE:  y_o = {{(`RV_XLEN-1){1'b0}}, ~lt_s};
      ALU_SGEU: y_o = {{(`RV_XLEN-1){1'b0}}, ~lt_u};
      default:  y_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rv_csr_file.sv */
`default_nettype none

`include "rv_exec_consts.svh"

module rv_csr_file (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                we_i,
  input  wire logic [11:0]         addr_i,
  input  wire logic [`RV_XLEN-1:0] wdata_i,
  input  wire logic                ecall_i,
  input  wire logic [`RV_XLEN-1:0] epc_i,
  output logic      [`RV_XLEN-1:0] rdata_o,
  output logic      [`RV_XLEN-1:0] mtvec_o,
  output logic      [`RV_XLEN-1:0] mepc_o
);

  logic [`RV_XLEN-1:0] mstatus;
  logic [`RV_XLEN-1:0] mtvec;
  logic [`RV_XLEN-1:0] mepc;
  logic [`RV_XLEN-1:0] mcause;

  always_comb begin
    case (addr_i)
      `RV_CSR_MSTATUS: rdata_o = mstatus;
      `RV_CSR_MTVEC:   rdata_o = mtvec;
      `RV_CSR_MEPC:    rdata_o = mepc;
      `RV_CSR_MCAUSE:  rdata_o = mcause;
      default:         rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= `RV_MTVEC_RESET;
      mepc    <= '0;
      mcause  <= '0;
    end else if (we_i) begin
      if (ecall_i) begin
        // trap entry, interrupts off
        mcause                    <= `RV_MCAUSE_ECALL_M;
        mepc                      <= epc_i;
        mstatus[`RV_MSTATUS_MPIE] <= mstatus[`RV_MSTATUS_MIE];
        mstatus[`RV_MSTATUS_MIE]  <= 1'b0;
      end else begin
        case (addr_i)
          `RV_CSR_MSTATUS: mstatus <= wdata_i;
          `RV_CSR_MTVEC:   mtvec   <= wdata_i;
          `RV_CSR_MEPC:    mepc    <= wdata_i;
          `RV_CSR_MCAUSE:  mcause  <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

/* rv_exec.f */
+incdir+.
rv_exec_pkg.sv
rv_alu.sv
rv_csr_file.sv
rv_exec_stage.sv
rv_pipe_reg.sv
rv_lsu.sv
rv_exec_top.sv
rv_exec_tb_clk.sv
rv_exec_properties.sv
rv_exec_tb.sv

/* rv_exec_consts.svh */
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

`define RV_XLEN 32

// major opcodes
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_SYSTEM 7'b1110011
`define RV_OP_LUI    7'b0110111

// funct3 under SYSTEM
`define RV_F3_PRIV   3'b000
`define RV_F3_CSRRW  3'b001
`define RV_F3_CSRRS  3'b010
`define RV_F3_CSRRC  3'b011
`define RV_F3_CSRRWI 3'b101
`define RV_F3_CSRRSI 3'b110
`define RV_F3_CSRRCI 3'b111

// load/store sizes
`define RV_F3_B  3'b000
`define RV_F3_H  3'b001
`define RV_F3_W  3'b010
`define RV_F3_BU 3'b100
`define RV_F3_HU 3'b101

`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MTVEC   12'h305
`define RV_CSR_MEPC    12'h341
`define RV_CSR_MCAUSE  12'h342

`define RV_IMM_ECALL 12'h000
`define RV_IMM_MRET  12'h302

`define RV_MSTATUS_MIE  3
`define RV_MSTATUS_MPIE 7

`define RV_MCAUSE_ECALL_M 32'd11
`define RV_MTVEC_RESET    32'h0000_0100

`define RV_DMEM_WORDS 256

`endif

/* rv_exec_pkg.sv */
`default_nettype none

`include "rv_exec_consts.svh"

package rv_exec_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // for BGE / BGEU
    ALU_SGE  = 4'd10,
    ALU_SGEU = 4'd11
  } alu_op_e;

  // execute to load/store payload
  typedef struct packed {
    logic                is_load;
    logic                is_store;
    logic [2:0]          size_f3;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] store_data;
    // result when not a load
    logic [`RV_XLEN-1:0] rd_data;
    logic [`RV_XLEN-1:0] npc;
  } ex_mem_t;

  // writeback result held in the lsu
  typedef struct packed {
    logic [`RV_XLEN-1:0] rd_data;
    logic [`RV_XLEN-1:0] npc;
  } wb_t;

endpackage

`default_nettype wire

/* rv_exec_properties.sv */
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_properties (
  input wire logic                clk,
  input wire logic                rst,
  input wire logic                issue_ready_i,
  input wire logic                mem_valid_i,
  input wire logic                valid_i,
  input wire logic                ready_i,
  input wire logic [`RV_XLEN-1:0] rd_data_i,
  input wire logic [`RV_XLEN-1:0] npc_i
);

  a_idle_after_reset: assert property (@(posedge clk) rst |=> !valid_i)
    else $error("result valid right after reset");

  // held result must not move while stalled
  a_hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
    valid_i && !ready_i |=> valid_i && $stable(rd_data_i) && $stable(npc_i))
    else $error("result changed while waiting for ready");

  a_ready_when_empty: assert property (@(posedge clk) disable iff (rst)
    !mem_valid_i && !valid_i |-> issue_ready_i)
    else $error("issue not ready with an empty pipeline");

endmodule

bind rv_exec_top rv_exec_properties u_properties (
  .clk           (clk),
  .rst           (rst),
  .issue_ready_i (issue_ready_o),
  .mem_valid_i   (mem_valid),
  .valid_i       (valid_o),
  .ready_i       (ready_i),
  .rd_data_i     (rd_data_o),
  .npc_i         (npc_o)
);

`default_nettype wire

/* rv_exec_stage.sv */
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_stage import rv_exec_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                valid_i,
  output logic                     ready_o,
  input  wire logic [6:0]          opcode_i,
  input  wire logic [2:0]          funct3_i,
  input  wire alu_op_e             alu_op_i,
  input  wire logic [`RV_XLEN-1:0] op1_i,
  input  wire logic [`RV_XLEN-1:0] op2_i,
  input  wire logic [`RV_XLEN-1:0] base_i,
  input  wire logic [`RV_XLEN-1:0] imm_i,
  input  wire logic [`RV_XLEN-1:0] pc_i,
  input  wire logic [`RV_XLEN-1:0] npc_i,
  input  wire logic [11:0]         csr_addr_i,
  output logic                     valid_o,
  input  wire logic                ready_i,
  output ex_mem_t                  payload_o
);

  logic [`RV_XLEN-1:0] alu_y;
  logic [`RV_XLEN-1:0] tgt;
  logic [`RV_XLEN-1:0] csr_rdata;
  logic [`RV_XLEN-1:0] csr_wdata;
  logic [`RV_XLEN-1:0] mtvec;
  logic [`RV_XLEN-1:0] mepc;
  logic [11:0]         csr_addr;
  logic                fire;
  logic                is_sys;
  logic                is_priv;
  logic                is_ecall;
  logic                is_mret;
  logic                csr_we;
  logic                br_taken;

  assign valid_o = valid_i;
  assign ready_o = ready_i;
  assign fire    = valid_i && ready_i;

  rv_alu u_alu (.a_i(op1_i), .b_i(op2_i), .op_i(alu_op_i), .y_o(alu_y));

  // address and jump target
  rv_alu u_agu (.a_i(base_i), .b_i(imm_i), .op_i(ALU_ADD), .y_o(tgt));

  assign is_sys   = opcode_i == `RV_OP_SYSTEM;
  assign is_priv  = is_sys && (funct3_i == `RV_F3_PRIV);
  assign is_ecall = is_priv && (imm_i[11:0] == `RV_IMM_ECALL);
  assign is_mret  = is_priv && (imm_i[11:0] == `RV_IMM_MRET);

  assign csr_addr = is_ecall ? `RV_CSR_MCAUSE :
                    is_mret  ? `RV_CSR_MSTATUS : csr_addr_i;
  // csr state only moves when the item leaves the stage
  assign csr_we   = fire && is_sys && (!is_priv || is_ecall || is_mret);

  always_comb begin
    csr_wdata = csr_rdata;
    case (funct3_i)
      `RV_F3_CSRRW, `RV_F3_CSRRWI: csr_wdata = op1_i;
      `RV_F3_CSRRS, `RV_F3_CSRRSI: csr_wdata = csr_rdata | op1_i;
      `RV_F3_CSRRC, `RV_F3_CSRRCI: csr_wdata = csr_rdata & ~op1_i;
      `RV_F3_PRIV: begin
        if (is_mret) begin
          csr_wdata[`RV_MSTATUS_MIE]  = csr_rdata[`RV_MSTATUS_MPIE];
          csr_wdata[`RV_MSTATUS_MPIE] = 1'b1;
        end
      end
      default: ;
    endcase
  end

  rv_csr_file u_csr (
    .clk     (clk),
    .rst     (rst),
    .we_i    (csr_we),
    .addr_i  (csr_addr),
    .wdata_i (csr_wdata),
    .ecall_i (is_ecall),
    .epc_i   (pc_i),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  // BEQ uses SUB and a zero difference means taken
  assign br_taken = (alu_op_i == ALU_SUB) ? (alu_y == '0) : (alu_y != '0);

  always_comb begin
    payload_o            = '0;
    payload_o.is_load    = opcode_i == `RV_OP_LOAD;
    payload_o.is_store   = opcode_i == `RV_OP_STORE;
    payload_o.size_f3    = funct3_i;
    payload_o.addr       = tgt;
    payload_o.store_data = op2_i;
    payload_o.rd_data    = alu_y;
    payload_o.npc        = npc_i;
    case (opcode_i)
      `RV_OP_JAL: begin
        payload_o.rd_data = npc_i;
        payload_o.npc     = tgt;
      end
      `RV_OP_JALR: begin
        payload_o.rd_data = npc_i;
        payload_o.npc     = {tgt[`RV_XLEN-1:1], 1'b0};
      end
      `RV_OP_BRANCH: begin
        if (br_taken) begin
          payload_o.npc = tgt;
        end
      end
      `RV_OP_SYSTEM: begin
        payload_o.rd_data = csr_rdata;
        if (is_ecall) begin
          payload_o.npc = mtvec;
        end else if (is_mret) begin
          payload_o.npc = mepc;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rv_exec_tb.sv */
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_tb import rv_exec_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 16;
  localparam int SEED       = 43293;
  localparam int ALU_PAIRS  = 20;
  // each alu pair counts as one test plus five directed groups
  localparam int WATCHDOG_CYCLES = RST_CYCLES + 200 * (ALU_PAIRS + 5);

  logic                clk;
  logic                rst;
  logic                issue_valid;
  logic                issue_ready;
  logic [6:0]          issue_opcode;
  logic [2:0]          issue_funct3;
  alu_op_e             issue_alu_op;
  logic [`RV_XLEN-1:0] issue_op1;
  logic [`RV_XLEN-1:0] issue_op2;
  logic [`RV_XLEN-1:0] issue_base;
  logic [`RV_XLEN-1:0] issue_imm;
  logic [`RV_XLEN-1:0] issue_pc;
  logic [`RV_XLEN-1:0] issue_npc;
  logic [11:0]         issue_csr_addr;
  logic                res_valid;
  logic                res_ready;
  logic [`RV_XLEN-1:0] res_rd;
  logic [`RV_XLEN-1:0] res_npc;
  logic [`RV_XLEN-1:0] mtvec_model;
  int                  cycle = 0;
  int                  accept_edge;

  rv_exec_tb_clk #(.PERIOD(CLK_PERIOD)) u_clk (.clk_o(clk));

  rv_exec_top dut (
    .clk              (clk),
    .rst              (rst),
    .issue_valid_i    (issue_valid),
    .issue_ready_o    (issue_ready),
    .issue_opcode_i   (issue_opcode),
    .issue_funct3_i   (issue_funct3),
    .issue_alu_op_i   (issue_alu_op),
    .issue_op1_i      (issue_op1),
    .issue_op2_i      (issue_op2),
    .issue_base_i     (issue_base),
    .issue_imm_i      (issue_imm),
    .issue_pc_i       (issue_pc),
    .issue_npc_i      (issue_npc),
    .issue_csr_addr_i (issue_csr_addr),
    .valid_o          (res_valid),
    .ready_i          (res_ready),
    .rd_data_o        (res_rd),
    .npc_o            (res_npc)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic compare_data(input logic [`RV_XLEN-1:0] got, exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s rd_data %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_npc(input logic [`RV_XLEN-1:0] got, exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s npc %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_latency(input int got, input string what);
    if (got != 2) begin
      abort_run($sformatf("Error at %0t: %s took %0d cycles, expected 2", $time, what, got));
    end
  endtask

  // reference ALU from the ISA rules
  function automatic logic [`RV_XLEN-1:0] alu_ref(
    input alu_op_e op, input logic [`RV_XLEN-1:0] a, b
  );
    logic [4:0]            sh;
    logic [2*`RV_XLEN-1:0] ext;
    logic                  slt;
    sh  = b[4:0];
    ext = {{`RV_XLEN{a[`RV_XLEN-1]}}, a} >> sh;
    // the negative one is smaller when the signs differ
    slt = (a[`RV_XLEN-1] != b[`RV_XLEN-1]) ? a[`RV_XLEN-1] : (a < b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return ext[`RV_XLEN-1:0];
      ALU_SLT:  return {{(`RV_XLEN-1){1'b0}}, slt};
      ALU_SLTU: return {{(`RV_XLEN-1){1'b0}}, a < b};
      ALU_SGE:  return {{(`RV_XLEN-1){1'b0}}, !slt};
      ALU_SGEU: return {{(`RV_XLEN-1){1'b0}}, !(a < b)};
      default:  return '0;
    endcase
  endfunction

  task automatic issue(
    input logic [6:0]          opcode,
    input logic [2:0]          f3,
    input alu_op_e             op,
    input logic [`RV_XLEN-1:0] a,
    input logic [`RV_XLEN-1:0] b,
    input logic [`RV_XLEN-1:0] base,
    input logic [`RV_XLEN-1:0] imm,
    input logic [`RV_XLEN-1:0] pc,
    input logic [11:0]         csr
  );
    @(posedge clk);
    issue_valid    <= 1'b1;
    issue_opcode   <= opcode;
    issue_funct3   <= f3;
    issue_alu_op   <= op;
    issue_op1      <= a;
    issue_op2      <= b;
    issue_base     <= base;
    issue_imm      <= imm;
    issue_pc       <= pc;
    issue_npc      <= pc + 4;
    issue_csr_addr <= csr;
    @(negedge clk);
    while (!issue_ready) @(negedge clk);
    accept_edge = cycle + 1;
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic collect(output logic [`RV_XLEN-1:0] rd, npc, output int lat);
    @(negedge clk);
    while (!res_valid) @(negedge clk);
    // the next edge is the first one to sample valid_o
    lat = cycle + 1 - accept_edge;
    while (!res_ready) @(negedge clk);
    rd  = res_rd;
    npc = res_npc;
    @(posedge clk);
  endtask

  task automatic run_instr(
    input  logic [6:0]          opcode,
    input  logic [2:0]          f3,
    input  alu_op_e             op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  logic [`RV_XLEN-1:0] base,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [11:0]         csr,
    output logic [`RV_XLEN-1:0] rd,
    output logic [`RV_XLEN-1:0] npc
  );
    int lat;
    issue(opcode, f3, op, a, b, base, imm, pc, csr);
    collect(rd, npc, lat);
    compare_latency(lat, "issue to result");
  endtask

  task automatic mem_op(
    input  logic [6:0]          opcode,
    input  logic [2:0]          size,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] data,
    output logic [`RV_XLEN-1:0] rd
  );
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] npc;
    pc = $urandom & ~32'h3;
    // word part in the base and byte offset in the immediate
    run_instr(opcode, size, ALU_ADD, '0, data, {addr[`RV_XLEN-1:2], 2'b00},
              {{(`RV_XLEN-2){1'b0}}, addr[1:0]}, pc, 12'h000, rd, npc);
    compare_npc(npc, pc + 4, "load/store");
  endtask

  task automatic csr_op(
    input  logic [2:0]          f3,
    input  logic [11:0]         addr,
    input  logic [`RV_XLEN-1:0] val,
    output logic [`RV_XLEN-1:0] rd
  );
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] npc;
    pc = $urandom & ~32'h3;
    run_instr(`RV_OP_SYSTEM, f3, ALU_ADD, val, '0, '0, '0, pc, addr, rd, npc);
    compare_npc(npc, pc + 4, "csr access");
  endtask

  task automatic branch_check(input string kind, input logic [`RV_XLEN-1:0] a, b);
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rd;
    logic [`RV_XLEN-1:0] npc;
    alu_op_e             op;
    logic                taken;
    pc  = $urandom & ~32'h3;
    // multiple of 8 so the target never equals pc + 4
    imm = (($urandom % 256) << 3) - 32'd1024;
    case (kind)
      "beq": begin
        op    = ALU_SUB;
        taken = a == b;
      end
      "bne": begin
        op    = ALU_XOR;
        taken = a != b;
      end
      "blt": begin
        op    = ALU_SLT;
        taken = $signed(a) < $signed(b);
      end
      default: begin
        op    = ALU_SGEU;
        taken = a >= b;
      end
    endcase
    run_instr(`RV_OP_BRANCH, 3'b000, op, a, b, pc, imm, pc, 12'h000, rd, npc);
    compare_npc(npc, taken ? pc + imm : pc + 4, kind);
  endtask

  task automatic alu_ops();
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rd;
    logic [`RV_XLEN-1:0] npc;
    alu_op_e             op;
    for (int i = 0; i < ALU_PAIRS; i++) begin
      a = $urandom;
      b = (i == 0) ? a : $urandom;
      op = op.first();
      do begin
        pc = $urandom & ~32'h3;
        run_instr(`RV_OP_OP, 3'b000, op, a, b, '0, '0, pc, 12'h000, rd, npc);
        compare_data(rd, alu_ref(op, a, b), op.name());
        compare_npc(npc, pc + 4, op.name());
        op = op.next();
      end while (op != op.first());
    end
  endtask

  task automatic loads_and_stores();
    logic [`RV_XLEN-1:0] wa;
    logic [`RV_XLEN-1:0] wb;
    logic [`RV_XLEN-1:0] d;
    logic [`RV_XLEN-1:0] rd;
    logic [`RV_XLEN-1:0] word_a;
    logic [`RV_XLEN-1:0] word_b;
    wa = ($urandom % `RV_DMEM_WORDS) << 2;
    // a different word so the two never alias
    wb = ((((wa >> 2) + 1 + ($urandom % (`RV_DMEM_WORDS - 1))) % `RV_DMEM_WORDS) << 2);
    d = $urandom;
    mem_op(`RV_OP_STORE, `RV_F3_W, wa, d, rd);
    word_a = d;
    d = $urandom | 32'h80;
    mem_op(`RV_OP_STORE, `RV_F3_B, wa + 1, d, rd);
    word_a[15:8] = d[7:0];
    d = $urandom | 32'h8000;
    mem_op(`RV_OP_STORE, `RV_F3_H, wa + 2, d, rd);
    word_a[31:16] = d[15:0];
    d = $urandom;
    mem_op(`RV_OP_STORE, `RV_F3_W, wb, d, rd);
    word_b = d;
    mem_op(`RV_OP_LOAD, `RV_F3_W, wa, '0, rd);
    compare_data(rd, word_a, "lw");
    mem_op(`RV_OP_LOAD, `RV_F3_B, wa + 1, '0, rd);
    compare_data(rd, {{24{word_a[15]}}, word_a[15:8]}, "lb");
    mem_op(`RV_OP_LOAD, `RV_F3_BU, wa + 3, '0, rd);
    compare_data(rd, {24'b0, word_a[31:24]}, "lbu");
    mem_op(`RV_OP_LOAD, `RV_F3_H, wa + 2, '0, rd);
    compare_data(rd, {{16{word_a[31]}}, word_a[31:16]}, "lh");
    mem_op(`RV_OP_LOAD, `RV_F3_HU, wa, '0, rd);
    compare_data(rd, {16'b0, word_a[15:0]}, "lhu");
    mem_op(`RV_OP_LOAD, `RV_F3_W, wb, '0, rd);
    compare_data(rd, word_b, "lw second word");
  endtask

  task automatic branches_and_jumps();
    logic [`RV_XLEN-1:0] x;
    logic [`RV_XLEN-1:0] neg;
    logic [`RV_XLEN-1:0] pos;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] base;
    logic [`RV_XLEN-1:0] rd;
    logic [`RV_XLEN-1:0] npc;
    x   = $urandom;
    neg = $urandom | 32'h8000_0000;
    pos = $urandom & 32'h7fff_ffff;
    branch_check("beq", x, x);
    branch_check("beq", x, x + 1);
    branch_check("bne", x, x + 1);
    branch_check("bne", x, x);
    branch_check("blt", neg, pos);
    branch_check("blt", pos, neg);
    branch_check("bgeu", neg, pos);
    branch_check("bgeu", pos, neg);
    pc = $urandom & ~32'h3;
    run_instr(`RV_OP_JAL, 3'b000, ALU_ADD, '0, '0, pc, 32'h800, pc, 12'h000, rd, npc);
    compare_data(rd, pc + 4, "jal link");
    compare_npc(npc, pc + 32'h800, "jal target");
    // odd sum so bit 0 must be cleared
    base = $urandom | 32'h1;
    run_instr(`RV_OP_JALR, 3'b000, ALU_ADD, base, '0, base, 32'h10, pc, 12'h000, rd, npc);
    compare_data(rd, pc + 4, "jalr link");
    compare_npc(npc, (base + 32'h10) & ~32'h1, "jalr target");
  endtask

  task automatic csr_access();
    logic [`RV_XLEN-1:0] v;
    logic [`RV_XLEN-1:0] rd;
    v = $urandom & ~32'h3;
    csr_op(`RV_F3_CSRRW, `RV_CSR_MTVEC, v, rd);
    compare_data(rd, mtvec_model, "csrrw old mtvec");
    mtvec_model = v;
    v = $urandom;
    csr_op(`RV_F3_CSRRS, `RV_CSR_MTVEC, v, rd);
    compare_data(rd, mtvec_model, "csrrs old mtvec");
    mtvec_model = mtvec_model | v;
    v = $urandom;
    csr_op(`RV_F3_CSRRC, `RV_CSR_MTVEC, v, rd);
    compare_data(rd, mtvec_model, "csrrc old mtvec");
    mtvec_model = mtvec_model & ~v;
    csr_op(`RV_F3_CSRRS, `RV_CSR_MTVEC, '0, rd);
    compare_data(rd, mtvec_model, "mtvec readback");
  endtask

  task automatic trap_entry_exit();
    logic [`RV_XLEN-1:0] epc;
    logic [`RV_XLEN-1:0] rd;
    logic [`RV_XLEN-1:0] npc;
    csr_op(`RV_F3_CSRRW, `RV_CSR_MSTATUS, 32'd1 << `RV_MSTATUS_MIE, rd);
    compare_data(rd, '0, "mstatus after reset");
    epc = $urandom & ~32'h3;
    run_instr(`RV_OP_SYSTEM, `RV_F3_PRIV, ALU_ADD, '0, '0, '0, {20'b0, `RV_IMM_ECALL},
              epc, 12'h000, rd, npc);
    compare_npc(npc, mtvec_model, "ecall target");
    csr_op(`RV_F3_CSRRS, `RV_CSR_MCAUSE, '0, rd);
    compare_data(rd, `RV_MCAUSE_ECALL_M, "mcause");
    csr_op(`RV_F3_CSRRS, `RV_CSR_MEPC, '0, rd);
    compare_data(rd, epc, "mepc");
    csr_op(`RV_F3_CSRRS, `RV_CSR_MSTATUS, '0, rd);
    compare_data(rd, 32'd1 << `RV_MSTATUS_MPIE, "mstatus after ecall");
    run_instr(`RV_OP_SYSTEM, `RV_F3_PRIV, ALU_ADD, '0, '0, '0, {20'b0, `RV_IMM_MRET},
              $urandom & ~32'h3, 12'h000, rd, npc);
    compare_npc(npc, epc, "mret target");
    csr_op(`RV_F3_CSRRS, `RV_CSR_MSTATUS, '0, rd);
    compare_data(rd, (32'd1 << `RV_MSTATUS_MIE) | (32'd1 << `RV_MSTATUS_MPIE),
                 "mstatus after mret");
  endtask

  task automatic back_pressure();
    logic [`RV_XLEN-1:0] exp_rd_q[$];
    logic [`RV_XLEN-1:0] exp_npc_q[$];
    logic                done;
    done = 1'b0;
    fork
      begin
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] pc;
        for (int i = 0; i < 3; i++) begin
          a  = $urandom;
          b  = $urandom;
          pc = $urandom & ~32'h3;
          exp_rd_q.push_back(a ^ b);
          exp_npc_q.push_back(pc + 4);
          issue(`RV_OP_OP, 3'b000, ALU_XOR, a, b, '0, '0, pc, 12'h000);
        end
      end
      begin
        logic [`RV_XLEN-1:0] rd;
        logic [`RV_XLEN-1:0] npc;
        int                  lat;
        for (int i = 0; i < 3; i++) begin
          collect(rd, npc, lat);
          compare_data(rd, exp_rd_q.pop_front(), "stalled result");
          compare_npc(npc, exp_npc_q.pop_front(), "stalled result");
        end
        done = 1'b1;
      end
      // random stall stretches with one open cycle between them
      while (!done) begin
        @(posedge clk);
        res_ready <= 1'b0;
        repeat (1 + $urandom % 6) @(posedge clk);
        res_ready <= 1'b1;
      end
    join
    @(posedge clk);
    res_ready <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (res_valid) begin
        abort_run("an extra result appeared after the last stalled instruction");
      end
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("timeout: the DUT did not finish all tests in the allowed time");
  end

  initial begin
    rst            = 1'b1;
    issue_valid    = 1'b0;
    issue_opcode   = '0;
    issue_funct3   = '0;
    issue_alu_op   = ALU_ADD;
    issue_op1      = '0;
    issue_op2      = '0;
    issue_base     = '0;
    issue_imm      = '0;
    issue_pc       = '0;
    issue_npc      = '0;
    issue_csr_addr = '0;
    res_ready      = 1'b1;
    mtvec_model    = `RV_MTVEC_RESET;
    void'($urandom(SEED));
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    alu_ops();
    loads_and_stores();
    branches_and_jumps();
    csr_access();
    trap_entry_exit();
    back_pressure();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_exec_tb_clk.sv */
`default_nettype none

module rv_exec_tb_clk #(
  parameter int PERIOD = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* rv_exec_top.sv */
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_top import rv_exec_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                issue_valid_i,
  output logic                     issue_ready_o,
  input  wire logic [6:0]          issue_opcode_i,
  input  wire logic [2:0]          issue_funct3_i,
  input  wire alu_op_e             issue_alu_op_i,
  input  wire logic [`RV_XLEN-1:0] issue_op1_i,
  input  wire logic [`RV_XLEN-1:0] issue_op2_i,
  input  wire logic [`RV_XLEN-1:0] issue_base_i,
  input  wire logic [`RV_XLEN-1:0] issue_imm_i,
  input  wire logic [`RV_XLEN-1:0] issue_pc_i,
  input  wire logic [`RV_XLEN-1:0] issue_npc_i,
  input  wire logic [11:0]         issue_csr_addr_i,
  output logic                     valid_o,
  input  wire logic                ready_i,
  output logic      [`RV_XLEN-1:0] rd_data_o,
  output logic      [`RV_XLEN-1:0] npc_o
);

  logic    ex_valid;
  logic    ex_ready;
  ex_mem_t ex_payload;
  logic    mem_valid;
  logic    mem_ready;
  ex_mem_t mem_req;

  rv_exec_stage u_exec (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (issue_valid_i),
    .ready_o    (issue_ready_o),
    .opcode_i   (issue_opcode_i),
    .funct3_i   (issue_funct3_i),
    .alu_op_i   (issue_alu_op_i),
    .op1_i      (issue_op1_i),
    .op2_i      (issue_op2_i),
    .base_i     (issue_base_i),
    .imm_i      (issue_imm_i),
    .pc_i       (issue_pc_i),
    .npc_i      (issue_npc_i),
    .csr_addr_i (issue_csr_addr_i),
    .valid_o    (ex_valid),
    .ready_i    (ex_ready),
    .payload_o  (ex_payload)
  );

  rv_pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk     (clk),
    .rst     (rst),
    .valid_i (ex_valid),
    .ready_o (ex_ready),
    .data_i  (ex_payload),
    .valid_o (mem_valid),
    .ready_i (mem_ready),
    .data_o  (mem_req)
  );

  rv_lsu u_lsu (
    .clk       (clk),
    .rst       (rst),
    .valid_i   (mem_valid),
    .ready_o   (mem_ready),
    .req_i     (mem_req),
    .valid_o   (valid_o),
    .ready_i   (ready_i),
    .rd_data_o (rd_data_o),
    .npc_o     (npc_o)
  );

endmodule

`default_nettype wire

/* rv_lsu.sv */
`default_nettype none

`include "rv_exec_consts.svh"

module rv_lsu import rv_exec_pkg::*; #(
  parameter int DEPTH = `RV_DMEM_WORDS
) (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                valid_i,
  output logic                     ready_o,
  input  ex_mem_t                  req_i,
  output logic                     valid_o,
  input  wire logic                ready_i,
  output logic      [`RV_XLEN-1:0] rd_data_o,
  output logic      [`RV_XLEN-1:0] npc_o
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [`RV_XLEN-1:0] mem [DEPTH];
  logic [IDX_W-1:0]    idx;
  logic [1:0]          lane;
  logic [3:0]          wmask;
  logic [`RV_XLEN-1:0] wdata;
  logic                acc;
  logic                valid_q;
  wb_t                 wb_q;
  logic [`RV_XLEN-1:0] rword_q;
  logic [1:0]          lane_q;
  logic [2:0]          size_q;
  logic                load_q;
  logic [`RV_XLEN-1:0] shifted;
  logic [`RV_XLEN-1:0] ld_data;

  assign ready_o = !valid_q || ready_i;
  assign acc     = valid_i && ready_o;

  // word index wraps at DEPTH
  assign idx  = req_i.addr[IDX_W+1:2];
  assign lane = req_i.addr[1:0];

  always_comb begin
    case (req_i.size_f3)
      `RV_F3_B: wmask = 4'b0001 << lane;
      `RV_F3_H: wmask = 4'b0011 << lane;
      default:  wmask = 4'b1111;
    endcase
  end

  assign wdata = req_i.store_data << {lane, 3'b000};

  always_ff @(posedge clk) begin
    if (acc && req_i.is_store) begin
      for (int b = 0; b < 4; b++) begin
        if (wmask[b]) begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc) begin
      rword_q <= mem[idx];
      lane_q  <= lane;
      size_q  <= req_i.size_f3;
      load_q  <= req_i.is_load;
      wb_q    <= '{rd_data: req_i.rd_data, npc: req_i.npc};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // lane select and extension of the read word
  assign shifted = rword_q >> {lane_q, 3'b000};

  always_comb begin
    case (size_q)
      `RV_F3_B:  ld_data = {{24{shifted[7]}}, shifted[7:0]};
      `RV_F3_H:  ld_data = {{16{shifted[15]}}, shifted[15:0]};
      `RV_F3_BU: ld_data = {24'b0, shifted[7:0]};
      `RV_F3_HU: ld_data = {16'b0, shifted[15:0]};
      default:   ld_data = rword_q;
    endcase
  end

  assign valid_o   = valid_q;
  assign rd_data_o = load_q ? ld_data : wb_q.rd_data;
  assign npc_o     = wb_q.npc;

endmodule

`default_nettype wire

/* rv_pipe_reg.sv */
`default_nettype none

module rv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic valid_i,
  output logic      ready_o,
  input  payload_t  data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output payload_t  data_o
);

  logic     valid_q;
  payload_t data_q;

  // empty, or draining this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire
